// File: tb.f
+incdir+.
mem_ctrl_pkg.sv
core_port_frontend.sv
access_arbiter.sv
axil_master_bridge.sv
mem_ctrl_top.sv
mem_ctrl_assertions.sv
tb_mem_model.sv
tb_mem_ctrl.sv

// File: Makefile
TOP = tb_mem_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
		--top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_mem_ctrl.sv
`include "mem_ctrl_macros.svh"

module tb_mem_ctrl
	import mem_ctrl_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] FILL_KEY = 32'h5a3c_96e1;
	localparam int N_BASIC  = 8;
	localparam int N_RANDOM = 40;
	// all requests of all tests, both ports together
	localparam int N_REQ       = N_BASIC + 3 * N_BASIC + 4 + 2 + 2 * N_RANDOM + 5;
	localparam int CYCLE_LIMIT = N_REQ * 40 + 200;
	localparam logic [31:0] ERR_BYTE = {6'b0, `MC_ERR_BASE, 2'b00};

	typedef struct packed {
		logic        rw;
		logic [31:0] add;
		logic [31:0] wdata;
		int          cycle;
	} issued_t;

	logic        clock_cntrl;
	logic        reset;
	logic        inst_req;
	logic        inst_rw;
	logic [31:0] inst_add;
	logic [31:0] inst_data;
	logic        inst_ready;
	logic        inst_done;
	mem_resp_t   inst_resp;
	logic        data_req;
	logic        data_rw;
	logic [31:0] data_add;
	logic [31:0] data_data;
	logic        data_ready;
	logic        data_done;
	mem_resp_t   data_resp;
	axil_req_t   axil_req;
	axil_resp_t  axil_resp;

	issued_t     inst_q[$];
	issued_t     data_q[$];
	logic [31:0] shadow [logic [`MC_WORD_ADDR_W-1:0]];
	string       test_name = "reset";
	int          cycle = 0;
	int          errors = 0;
	int          checks = 0;
	int          axi_starts = 0;
	int          axi_before;
	integer      seed = 32'h3cfa;

	mem_ctrl_top dut (
		.clock_cntrl_i (clock_cntrl),
		.reset_i       (reset),
		.inst_req_i    (inst_req),
		.inst_rw_i     (inst_rw),
		.inst_add_i    (inst_add),
		.inst_data_i   (inst_data),
		.inst_ready_o  (inst_ready),
		.inst_done_o   (inst_done),
		.inst_resp_o   (inst_resp),
		.data_req_i    (data_req),
		.data_rw_i     (data_rw),
		.data_add_i    (data_add),
		.data_data_i   (data_data),
		.data_ready_o  (data_ready),
		.data_done_o   (data_done),
		.data_resp_o   (data_resp),
		.axil_req_o    (axil_req),
		.axil_resp_i   (axil_resp)
	);

	tb_mem_model #(
		.FILL_KEY (FILL_KEY)
	) u_mem (
		.clock_cntrl_i (clock_cntrl),
		.reset_i       (reset),
		.axil_req_i    (axil_req),
		.axil_resp_o   (axil_resp)
	);

	initial begin
		clock_cntrl = 1'b0;
		forever #4 clock_cntrl = ~clock_cntrl;
	end

	always @(posedge clock_cntrl) begin
		cycle <= cycle + 1;
		// transactions started on AR or AW
		if ((axil_req.ar_valid && axil_resp.ar_ready) || (axil_req.aw_valid && axil_resp.aw_ready))
			axi_starts <= axi_starts + 1;
	end

	// ------------------------------------------------------------
	// reference model and checks
	// ------------------------------------------------------------

	function automatic mem_resp_t ref_access(input logic is_data, input logic rw,
		input logic [31:0] add, input logic [31:0] wdata);
		mem_resp_t                  expected;
		logic [`MC_WORD_ADDR_W-1:0] word;
		expected = '0;
		word     = add[`MC_WORD_ADDR_W+1:2];
		if (add[1:0] != 2'b00)
			expected.status = mem_misaligned;
		else if (rw && !is_data)
			expected.status = mem_write_denied;
		else if (word >= `MC_ERR_BASE)
			expected.status = mem_bus_error;
		else if (rw)
			shadow[word] = wdata;
		else if (shadow.exists(word))
			expected.rdata = shadow[word];
		else
			expected.rdata = {8'h00, word} ^ FILL_KEY;
		return expected;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic complete(input logic is_data, input mem_resp_t actual);
		issued_t   item;
		mem_resp_t expected;
		int        latency;
		string     port;
		port = is_data ? "data" : "instruction";
		if ((is_data ? data_q.size() : inst_q.size()) == 0) begin
			errors++;
			$display("done pulse on the %s port with no request outstanding", port);
			return;
		end
		if (is_data)
			item = data_q.pop_front();
		else
			item = inst_q.pop_front();
		expected = ref_access(is_data, item.rw, item.add, item.wdata);
		latency  = cycle - item.cycle;
		check_value(test_name, 64'(expected), 64'(actual));
		if (expected.status == mem_misaligned || expected.status == mem_write_denied) begin
			if (latency != 1) begin
				errors++;
				$display("rejected %s request finished after %0d cycles, not one", port, latency);
			end
		end else if (latency < 4) begin
			errors++;
			$display("%s request finished too early, after %0d cycles", port, latency);
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clock_cntrl) begin
		if (reset) begin
			if (inst_done)
				complete(1'b0, inst_resp);
			if (data_done)
				complete(1'b1, data_resp);
		end
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------

	task automatic issue(input logic is_data, input logic rw, input logic [31:0] add,
		input logic [31:0] wdata);
		issued_t item;
		item.rw    = rw;
		item.add   = add;
		item.wdata = wdata;
		@(posedge clock_cntrl);
		#1;
		while ((is_data ? data_ready : inst_ready) !== 1'b1) begin
			@(posedge clock_cntrl);
			#1;
		end
		item.cycle = cycle;
		if (is_data) begin
			data_req  = 1'b1;
			data_rw   = rw;
			data_add  = add;
			data_data = wdata;
			data_q.push_back(item);
		end else begin
			inst_req  = 1'b1;
			inst_rw   = rw;
			inst_add  = add;
			inst_data = wdata;
			inst_q.push_back(item);
		end
		@(posedge clock_cntrl);
		#1;
		if (is_data)
			data_req = 1'b0;
		else
			inst_req = 1'b0;
	endtask

	task automatic wait_idle();
		while (inst_q.size() != 0 || data_q.size() != 0 || inst_ready !== 1'b1 ||
			data_ready !== 1'b1) begin
			@(posedge clock_cntrl);
			#1;
		end
	endtask

	// random word in a 64-word window, now and then misaligned
	task automatic random_access(input logic is_data);
		logic [31:0] pick;
		logic [31:0] add;
		pick = $random(seed);
		add  = 32'h2000 | {24'h0, pick[5:0], 2'b00};
		if (pick[11:8] == 4'h0)
			add[1:0] = pick[13:12] | 2'b01;
		issue(is_data, is_data & pick[16], add, $random(seed));
	endtask

	initial begin
		inst_req  = 1'b0;
		inst_rw   = 1'b0;
		inst_add  = '0;
		inst_data = '0;
		data_req  = 1'b0;
		data_rw   = 1'b0;
		data_add  = '0;
		data_data = '0;
		reset     = 1'b0;
		repeat (10) @(posedge clock_cntrl);
		#1;
		reset = 1'b1;
		check_value("reset_state", 64'b1_1000_0000,
			64'({inst_ready, data_ready, inst_done, data_done, axil_req.aw_valid,
			axil_req.w_valid, axil_req.ar_valid, axil_req.b_ready, axil_req.r_ready}));

		test_name = "inst_unwritten_read";
		for (int i = 0; i < N_BASIC; i++)
			issue(1'b0, 1'b0, 32'h1000 + i * 4, '0);
		wait_idle();

		test_name = "data_write_read";
		for (int i = 0; i < N_BASIC; i++)
			issue(1'b1, 1'b1, 32'h2000 + i * 4, $random(seed));
		for (int i = 0; i < N_BASIC; i++)
			issue(1'b1, 1'b0, 32'h2000 + i * 4, '0);
		for (int i = 0; i < N_BASIC; i++)
			issue(1'b0, 1'b0, 32'h2000 + i * 4, '0);
		wait_idle();

		test_name  = "misaligned";
		axi_before = axi_starts;
		fork
			begin
				issue(1'b0, 1'b0, 32'h3001, '0);
				issue(1'b0, 1'b0, 32'h3002, '0);
			end
			begin
				issue(1'b1, 1'b1, 32'h3003, 32'h1234_5678);
				issue(1'b1, 1'b0, 32'h3006, '0);
			end
		join
		wait_idle();
		check_value("misaligned_no_axi", 64'(axi_before), 64'(axi_starts));

		test_name = "inst_write_denied";
		issue(1'b0, 1'b1, 32'h2000, 32'hdead_beef);
		issue(1'b1, 1'b0, 32'h2000, '0);
		wait_idle();

		test_name = "random_traffic";
		fork
			for (int i = 0; i < N_RANDOM; i++)
				random_access(1'b0);
			for (int i = 0; i < N_RANDOM; i++)
				random_access(1'b1);
		join
		wait_idle();

		test_name = "bus_error";
		issue(1'b1, 1'b1, ERR_BYTE, 32'hcafe_f00d);
		issue(1'b1, 1'b0, ERR_BYTE + 32'h14, '0);
		issue(1'b0, 1'b0, ERR_BYTE + 32'h400, '0);
		issue(1'b0, 1'b0, 32'h1000, '0);
		issue(1'b1, 1'b0, 32'h2000, '0);
		wait_idle();

		errors = errors + dut.u_bridge.u_bus_checks.fail_count
			+ dut.u_inst_port.u_port_checks.fail_count
			+ dut.u_data_port.u_port_checks.fail_count;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// a request that never completes ends here
	initial begin
		wait (cycle >= CYCLE_LIMIT);
		$display("timeout after %0d cycles, a request never completed", cycle);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: tb_mem_model.sv
`include "mem_ctrl_macros.svh"

module tb_mem_model
	import mem_ctrl_pkg::*;
#(
	parameter logic [31:0] FILL_KEY = 32'h5a3c_96e1
) (
	input  logic       clock_cntrl_i,
	input  logic       reset_i,
	input  axil_req_t  axil_req_i,
	output axil_resp_t axil_resp_o
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [`MC_DATA_W-1:0]      mem [logic [`MC_WORD_ADDR_W-1:0]];
	axil_resp_t                 resp_q;
	logic                       aw_got;
	logic                       w_got;
	logic                       rd_wait;
	logic [`MC_WORD_ADDR_W-1:0] wr_word;
	logic [`MC_WORD_ADDR_W-1:0] rd_word;
	logic [`MC_DATA_W-1:0]      wr_data;
	logic                       aw_hs;
	logic                       w_hs;
	logic                       ar_hs;
	integer                     seed = 32'h3cfa;

	// three cycles out of four on average
	function logic go_now();
		return ($random(seed) & 3) != 0;
	endfunction

	assign axil_resp_o = resp_q;
	assign aw_hs = axil_req_i.aw_valid & resp_q.aw_ready;
	assign w_hs  = axil_req_i.w_valid & resp_q.w_ready;
	assign ar_hs = axil_req_i.ar_valid & resp_q.ar_ready;

	always @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			resp_q  <= '0;
			aw_got  <= 1'b0;
			w_got   <= 1'b0;
			rd_wait <= 1'b0;
		end else begin
			// readies drawn at random, dropped once the beat is taken
			resp_q.aw_ready <= !aw_got && !aw_hs && go_now();
			resp_q.w_ready  <= !w_got && !w_hs && go_now();
			resp_q.ar_ready <= !rd_wait && !ar_hs && !resp_q.r_valid && go_now();
			if (aw_hs) begin
				aw_got  <= 1'b1;
				wr_word <= axil_req_i.aw_addr[`MC_WORD_ADDR_W+1:2];
			end
			if (w_hs) begin
				w_got   <= 1'b1;
				wr_data <= axil_req_i.w_data;
			end
			// write response once address and data both arrived
			if (aw_got && w_got && !resp_q.b_valid && go_now()) begin
				aw_got         <= 1'b0;
				w_got          <= 1'b0;
				resp_q.b_valid <= 1'b1;
				if (wr_word >= `MC_ERR_BASE) begin
					resp_q.b_resp <= axi_slverr;
				end else begin
					resp_q.b_resp <= axi_okay;
					mem[wr_word] = wr_data;
				end
			end else if (resp_q.b_valid && axil_req_i.b_ready) begin
				resp_q.b_valid <= 1'b0;
			end
			if (ar_hs) begin
				rd_wait <= 1'b1;
				rd_word <= axil_req_i.ar_addr[`MC_WORD_ADDR_W+1:2];
			end
			if (rd_wait && !resp_q.r_valid && go_now()) begin
				rd_wait        <= 1'b0;
				resp_q.r_valid <= 1'b1;
				resp_q.r_resp  <= (rd_word >= `MC_ERR_BASE) ? axi_slverr : axi_okay;
				if (rd_word >= `MC_ERR_BASE)
					resp_q.r_data <= '0;
				else if (mem.exists(rd_word))
					resp_q.r_data <= mem[rd_word];
				else
					resp_q.r_data <= {8'h00, rd_word} ^ FILL_KEY;
			end else if (resp_q.r_valid && axil_req_i.r_ready) begin
				resp_q.r_valid <= 1'b0;
			end
		end
	end

endmodule

// File: mem_ctrl_assertions.sv
module mem_ctrl_assertions (
	input  logic       clock_cntrl_i,
	input  logic       reset_i,
	input  logic [2:0] axi_valid_i,
	input  logic [2:0] axi_ready_i,
	input  logic       done_i,
	input  logic       pend_i,
	input  logic       ready_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// read back by the testbench top
	int unsigned fail_count = 0;

	// ------------------------------------------------------------
	// AXI4-Lite master channels, bit 2 AW, bit 1 W, bit 0 AR
	// ------------------------------------------------------------

	genvar ch;
	for (ch = 0; ch < 3; ch++) begin : g_valid_hold
		valid_held: assert property (@(posedge clock_cntrl_i) disable iff (!reset_i)
			axi_valid_i[ch] && !axi_ready_i[ch] |=> axi_valid_i[ch])
		else begin
			fail_count++;
			$error("AXI valid %0d dropped before its ready", ch);
		end
	end

	// ------------------------------------------------------------
	// core port
	// ------------------------------------------------------------

	done_single: assert property (@(posedge clock_cntrl_i) disable iff (!reset_i)
		done_i |=> !done_i)
	else begin
		fail_count++;
		$error("done pulse longer than one cycle");
	end

	// a held request leaves through the done cycle, never straight to ready
	ready_low_when_held: assert property (@(posedge clock_cntrl_i) disable iff (!reset_i)
		pend_i |=> !ready_i)
	else begin
		fail_count++;
		$error("port ready right after a held request without a done cycle");
	end

endmodule

bind axil_master_bridge mem_ctrl_assertions u_bus_checks (
	.clock_cntrl_i (clock_cntrl_i),
	.reset_i       (reset_i),
	.axi_valid_i   ({axil_req_o.aw_valid, axil_req_o.w_valid, axil_req_o.ar_valid}),
	.axi_ready_i   ({axil_resp_i.aw_ready, axil_resp_i.w_ready, axil_resp_i.ar_ready}),
	.done_i        (1'b0),
	.pend_i        (1'b0),
	.ready_i       (1'b1)
);

bind core_port_frontend mem_ctrl_assertions u_port_checks (
	.clock_cntrl_i (clock_cntrl_i),
	.reset_i       (reset_i),
	.axi_valid_i   (3'b000),
	.axi_ready_i   (3'b000),
	.done_i        (done_o),
	.pend_i        (pend_o),
	.ready_i       (ready_o)
);

// File: mem_ctrl_top.sv
module mem_ctrl_top
	import mem_ctrl_pkg::*;
(
	input  logic       clock_cntrl_i,
	input  logic       reset_i,

	// instruction port
	input  logic       inst_req_i,
	input  logic       inst_rw_i,
	input  logic [31:0] inst_add_i,
	input  logic [31:0] inst_data_i,
	output logic       inst_ready_o,
	output logic       inst_done_o,
	output mem_resp_t  inst_resp_o,

	// data port
	input  logic       data_req_i,
	input  logic       data_rw_i,
	input  logic [31:0] data_add_i,
	input  logic [31:0] data_data_i,
	output logic       data_ready_o,
	output logic       data_done_o,
	output mem_resp_t  data_resp_o,

	// memory
	output axil_req_t  axil_req_o,
	input  axil_resp_t axil_resp_i
);

	logic      inst_pend;
	mem_req_t  inst_pend_req;
	logic      inst_grant_done;
	mem_resp_t inst_grant_resp;

	logic      data_pend;
	mem_req_t  data_pend_req;
	logic      data_grant_done;
	mem_resp_t data_grant_resp;

	logic      bus_valid;
	mem_req_t  bus_req;
	logic      bus_ack;
	mem_resp_t bus_resp;

	// ------------------------------------------------------------
	// core ports
	// ------------------------------------------------------------

	// instruction side is read only
	core_port_frontend #(
		.ALLOW_WRITE (1'b0)
	) u_inst_port (
		.clock_cntrl_i (clock_cntrl_i),
		.reset_i       (reset_i),
		.req_i         (inst_req_i),
		.rw_i          (inst_rw_i),
		.add_i         (inst_add_i),
		.data_i        (inst_data_i),
		.ready_o       (inst_ready_o),
		.done_o        (inst_done_o),
		.resp_o        (inst_resp_o),
		.pend_o        (inst_pend),
		.pend_req_o    (inst_pend_req),
		.grant_done_i  (inst_grant_done),
		.grant_resp_i  (inst_grant_resp)
	);

	core_port_frontend #(
		.ALLOW_WRITE (1'b1)
	) u_data_port (
		.clock_cntrl_i (clock_cntrl_i),
		.reset_i       (reset_i),
		.req_i         (data_req_i),
		.rw_i          (data_rw_i),
		.add_i         (data_add_i),
		.data_i        (data_data_i),
		.ready_o       (data_ready_o),
		.done_o        (data_done_o),
		.resp_o        (data_resp_o),
		.pend_o        (data_pend),
		.pend_req_o    (data_pend_req),
		.grant_done_i  (data_grant_done),
		.grant_resp_i  (data_grant_resp)
	);

	// ------------------------------------------------------------
	// arbitration and memory bus
	// ------------------------------------------------------------

	access_arbiter u_arbiter (
		.clock_cntrl_i (clock_cntrl_i),
		.reset_i       (reset_i),
		.inst_pend_i   (inst_pend),
		.inst_req_i    (inst_pend_req),
		.data_pend_i   (data_pend),
		.data_req_i    (data_pend_req),
		.inst_done_o   (inst_grant_done),
		.data_done_o   (data_grant_done),
		.inst_resp_o   (inst_grant_resp),
		.data_resp_o   (data_grant_resp),
		.valid_o       (bus_valid),
		.req_o         (bus_req),
		.ack_i         (bus_ack),
		.resp_i        (bus_resp)
	);

	axil_master_bridge u_bridge (
		.clock_cntrl_i (clock_cntrl_i),
		.reset_i       (reset_i),
		.valid_i       (bus_valid),
		.req_i         (bus_req),
		.ack_o         (bus_ack),
		.resp_o        (bus_resp),
		.axil_req_o    (axil_req_o),
		.axil_resp_i   (axil_resp_i)
	);

endmodule

// File: axil_master_bridge.sv
`include "mem_ctrl_macros.svh"

module axil_master_bridge
	import mem_ctrl_pkg::*;
(
	input  logic       clock_cntrl_i,
	input  logic       reset_i,

	// arbiter side
	input  logic       valid_i,
	input  mem_req_t   req_i,
	output logic       ack_o,
	output mem_resp_t  resp_o,

	// AXI4-Lite master port
	output axil_req_t  axil_req_o,
	input  axil_resp_t axil_resp_i
);

	typedef enum logic [2:0] {
		st_idle,
		st_wr_addr,
		st_wr_resp,
		st_rd_addr,
		st_rd_data,
		st_done
	} state_e;

	state_e    state_q;
	logic      aw_pend_q;
	logic      w_pend_q;
	logic      aw_left;
	logic      w_left;
	mem_resp_t resp_q;
	logic      [`MC_AXI_ADDR_W-1:0] byte_addr;

	// word address times four, zero extended
	assign byte_addr = {{(`MC_AXI_ADDR_W - `MC_WORD_ADDR_W - 2){1'b0}}, req_i.addr, 2'b00};

	// AW and W still waiting after this cycle
	assign aw_left = aw_pend_q & ~axil_resp_i.aw_ready;
	assign w_left  = w_pend_q & ~axil_resp_i.w_ready;

	// ------------------------------------------------------------
	// transaction FSM
	// ------------------------------------------------------------

	always_ff @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			state_q   <= st_idle;
			aw_pend_q <= 1'b0;
			w_pend_q  <= 1'b0;
		end else begin
			case (state_q)
				st_idle: begin
					if (valid_i) begin
						if (req_i.wr) begin
							state_q   <= st_wr_addr;
							aw_pend_q <= 1'b1;
							w_pend_q  <= 1'b1;
						end else begin
							state_q <= st_rd_addr;
						end
					end
				end
				st_wr_addr: begin
					// each channel drops on its own ready
					aw_pend_q <= aw_left;
					w_pend_q  <= w_left;
					if (!aw_left && !w_left)
						state_q <= st_wr_resp;
				end
				st_wr_resp: begin
					if (axil_resp_i.b_valid)
						state_q <= st_done;
				end
				st_rd_addr: begin
					if (axil_resp_i.ar_ready)
						state_q <= st_rd_data;
				end
				st_rd_data: begin
					if (axil_resp_i.r_valid)
						state_q <= st_done;
				end
				default: begin
					state_q <= st_idle;
				end
			endcase
		end
	end

	// response capture
	always_ff @(posedge clock_cntrl_i) begin
		if (state_q == st_wr_resp && axil_resp_i.b_valid) begin
			resp_q.rdata  <= '0;
			resp_q.status <= axil_resp_i.b_resp[1] ? mem_bus_error : mem_ok;
		end else if (state_q == st_rd_data && axil_resp_i.r_valid) begin
			resp_q.rdata  <= axil_resp_i.r_data;
			resp_q.status <= axil_resp_i.r_resp[1] ? mem_bus_error : mem_ok;
		end
	end

	// ------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------

	always_comb begin
		axil_req_o          = '0;
		axil_req_o.aw_valid = (state_q == st_wr_addr) & aw_pend_q;
		axil_req_o.aw_addr  = byte_addr;
		axil_req_o.w_valid  = (state_q == st_wr_addr) & w_pend_q;
		axil_req_o.w_data   = req_i.wdata;
		axil_req_o.b_ready  = (state_q == st_wr_resp);
		axil_req_o.ar_valid = (state_q == st_rd_addr);
		axil_req_o.ar_addr  = byte_addr;
		axil_req_o.r_ready  = (state_q == st_rd_data);
	end

	assign ack_o  = (state_q == st_done);
	assign resp_o = resp_q;

endmodule

// File: access_arbiter.sv
module access_arbiter
	import mem_ctrl_pkg::*;
(
	input  logic      clock_cntrl_i,
	input  logic      reset_i,

	// frontends
	input  logic      inst_pend_i,
	input  mem_req_t  inst_req_i,
	input  logic      data_pend_i,
	input  mem_req_t  data_req_i,
	output logic      inst_done_o,
	output logic      data_done_o,
	output mem_resp_t inst_resp_o,
	output mem_resp_t data_resp_o,

	// bridge
	output logic      valid_o,
	output mem_req_t  req_o,
	input  logic      ack_i,
	input  mem_resp_t resp_i
);

	typedef enum logic {
		own_inst,
		own_data
	} owner_e;

	owner_e owner_q;
	logic   valid_q;
	logic   inst_owns;
	logic   data_owns;

	// ------------------------------------------------------------
	// ownership
	// ------------------------------------------------------------

	// instruction side by default.
	// data side only when instruction side is idle,
	// and it keeps access until its transaction is acked
	always_ff @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			owner_q <= own_inst;
			valid_q <= 1'b0;
		end else if (!valid_q) begin
			if (inst_pend_i) begin
				owner_q <= own_inst;
				valid_q <= 1'b1;
			end else if (data_pend_i) begin
				owner_q <= own_data;
				valid_q <= 1'b1;
			end else begin
				owner_q <= own_inst;
			end
		end else if (ack_i) begin
			// owner stays until the next decision
			valid_q <= 1'b0;
		end
	end

	assign inst_owns = (owner_q == own_inst);
	assign data_owns = (owner_q == own_data);

	// ------------------------------------------------------------
	// request forwarding
	// ------------------------------------------------------------

	// frontend holds its request until done, so this stays stable
	assign valid_o = valid_q;
	assign req_o   = data_owns ? data_req_i : inst_req_i;

	// ------------------------------------------------------------
	// response routing
	// ------------------------------------------------------------

	// completion goes to the owner only
	assign inst_done_o = valid_q & ack_i & inst_owns;
	assign data_done_o = valid_q & ack_i & data_owns;

	assign inst_resp_o = inst_owns ? resp_i : '0;
	assign data_resp_o = data_owns ? resp_i : '0;

endmodule

// File: core_port_frontend.sv
`include "mem_ctrl_macros.svh"

module core_port_frontend
	import mem_ctrl_pkg::*;
#(
	parameter bit ALLOW_WRITE = 1'b1
) (
	input  logic        clock_cntrl_i,
	input  logic        reset_i,

	// core side
	input  logic        req_i,
	input  logic        rw_i,
	input  logic [31:0] add_i,
	input  logic [31:0] data_i,
	output logic        ready_o,
	output logic        done_o,
	output mem_resp_t   resp_o,

	// arbiter side
	output logic        pend_o,
	output mem_req_t    pend_req_o,
	input  logic        grant_done_i,
	input  mem_resp_t   grant_resp_i
);

	logic        pend_q;
	logic        done_q;
	mem_req_t    req_q;
	mem_resp_t   resp_q;
	logic        accept;
	logic        misaligned;
	logic        denied;
	mem_status_e reject_status;

	// ------------------------------------------------------------
	// request checks
	// ------------------------------------------------------------

	// word access only, any low address bit set is an error
	assign misaligned = |add_i[1:0];
	assign denied     = rw_i & ~ALLOW_WRITE;

	// misalignment wins over a denied write
	assign reject_status = misaligned ? mem_misaligned :
	                       denied     ? mem_write_denied : mem_ok;

	// busy while held and during the done cycle
	assign ready_o = ~(pend_q | done_q);
	assign accept  = req_i & ready_o;

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------

	always_ff @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			pend_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (accept) begin
				// rejected requests finish here, never seen by the arbiter
				if (misaligned || denied)
					done_q <= 1'b1;
				else
					pend_q <= 1'b1;
			end else if (pend_q && grant_done_i) begin
				pend_q <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// held request and response
	// ------------------------------------------------------------

	always_ff @(posedge clock_cntrl_i) begin
		if (accept) begin
			// byte address to word address
			req_q.addr    <= add_i[`MC_ADDR_MSB:2];
			req_q.wr      <= rw_i;
			req_q.wdata   <= data_i;
			resp_q.rdata  <= '0;
			resp_q.status <= reject_status;
		end else if (pend_q && grant_done_i) begin
			resp_q <= grant_resp_i;
		end
	end

	assign pend_o     = pend_q;
	assign pend_req_o = req_q;
	assign done_o     = done_q;
	assign resp_o     = resp_q;

endmodule

// File: mem_ctrl_pkg.sv
`include "mem_ctrl_macros.svh"

package mem_ctrl_pkg;

	// ------------------------------------------------------------
	// core side
	// ------------------------------------------------------------

	// completion status reported with every done pulse
	typedef enum logic [1:0] {
		mem_ok,
		mem_misaligned,
		mem_write_denied,
		mem_bus_error
	} mem_status_e;

	// one held word request
	typedef struct packed {
		logic [`MC_WORD_ADDR_W-1:0] addr;
		logic                       wr;
		logic [`MC_DATA_W-1:0]      wdata;
	} mem_req_t;

	// read data is zero for writes and rejected requests
	typedef struct packed {
		logic [`MC_DATA_W-1:0] rdata;
		mem_status_e           status;
	} mem_resp_t;

	// ------------------------------------------------------------
	// AXI4-Lite side
	// ------------------------------------------------------------

	typedef enum logic [1:0] {
		axi_okay,
		axi_exokay,
		axi_slverr,
		axi_decerr
	} axil_resp_e;

	// master to slave
	typedef struct packed {
		logic                      aw_valid;
		logic [`MC_AXI_ADDR_W-1:0] aw_addr;
		logic                      w_valid;
		logic [`MC_DATA_W-1:0]     w_data;
		logic                      b_ready;
		logic                      ar_valid;
		logic [`MC_AXI_ADDR_W-1:0] ar_addr;
		logic                      r_ready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic                  aw_ready;
		logic                  w_ready;
		logic                  b_valid;
		axil_resp_e            b_resp;
		logic                  ar_ready;
		logic                  r_valid;
		logic [`MC_DATA_W-1:0] r_data;
		axil_resp_e            r_resp;
	} axil_resp_t;

endpackage

// File: mem_ctrl_macros.svh
`ifndef MEM_CTRL_MACROS_SVH
`define MEM_CTRL_MACROS_SVH

// ------------------------------------------------------------
// memory controller widths
// ------------------------------------------------------------

// word address toward memory, byte address bits 25:2
`define MC_WORD_ADDR_W 24

// data word
`define MC_DATA_W 32

// byte address on the AXI4-Lite side
`define MC_AXI_ADDR_W 32

// highest core byte-address bit that still selects a memory word
`define MC_ADDR_MSB (`MC_WORD_ADDR_W + 1)

// ------------------------------------------------------------
// memory map
// ------------------------------------------------------------

// first word address of the region that answers SLVERR
`define MC_ERR_BASE 24'hF0_0000

`endif
